/* src/dcache_pkg.sv */
/*
  shared widths and types for the two-way write-back data cache.
  every cache module and the bench import this package, so the
  word size, line size and controller state encoding stay in one place.
*/
package dcache_pkg;

  localparam int ADDR_W         = 32;  // byte address
  localparam int WORD_W         = 32;
  localparam int WORDS_PER_LINE = 4;
  localparam int OFFSET_W       = 4;   // byte offset within a line

  // one cache line, word 0 in the low bits
  typedef logic [WORDS_PER_LINE-1:0][WORD_W-1:0] line_t;

  // controller states
  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    STORE,        // merged store line written back into the data array
    MISS_DIRTY,   // waiting for wr_rdy
    WRITEBACK,    // waiting for wr_valid
    MISS_CLEAN,   // waiting for rd_rdy
    REFILL        // waiting for ret_valid
  } ctrl_state_e;

endpackage

/* src/cache_ram.sv */
/*
  single-port array with a registered read port.
  the payload type is a parameter, so the same block holds the
  tag/valid entries and the data lines of each way.
  dout updates one cycle after en and keeps its value while en is low.
*/
module cache_ram #(
  parameter int  INDEX_W   = 4,
  parameter type payload_t = logic
) (
  input  logic               clk,
  input  logic               en,
  input  logic               we,
  input  logic [INDEX_W-1:0] index,
  input  payload_t           din,
  output payload_t           dout
);

  payload_t mem [2**INDEX_W];

  always_ff @(posedge clk) begin
    if (en) begin
      if (we) begin
        mem[index] <= din;
      end
      dout <= mem[index];  // read-before-write
    end
  end

endmodule

/* src/dcache_tag_check.sv */
/*
  hit detection and replacement state for the two ways.
  compares the tags read from the tag arrays against the buffered
  request, and keeps one dirty bit per way and set plus one LRU bit
  per set. the LRU bit names the way to evict next.
  way_hit, victim_way and victim_dirty are combinational.
*/
module dcache_tag_check import dcache_pkg::*; #(
  parameter int INDEX_W = 4
) (
  input  logic                                          clk,
  input  logic                                          resetn,
  input  logic [ADDR_W-INDEX_W-OFFSET_W-1:0]            lookup_tag,
  input  logic [INDEX_W-1:0]                            lookup_index,
  input  logic [1:0][ADDR_W-INDEX_W-OFFSET_W-1:0]       way_tag,
  input  logic [1:0]                                    way_valid,
  input  logic                                          hit_update,
  input  logic                                          hit_store,
  input  logic                                          fill_update,
  input  logic                                          clean_victim,
  output logic [1:0]                                    way_hit,
  output logic                                          victim_way,
  output logic                                          victim_dirty
);

  localparam int SETS = 2**INDEX_W;

  logic [1:0][SETS-1:0] dirty;
  logic [SETS-1:0]      lru;     // 1 -> evict way 1 next
  logic                 hit_way;

  assign way_hit[0] = way_valid[0] && (way_tag[0] == lookup_tag);
  assign way_hit[1] = way_valid[1] && (way_tag[1] == lookup_tag);
  assign hit_way    = way_hit[1];

  assign victim_way   = lru[lookup_index];
  assign victim_dirty = dirty[victim_way][lookup_index];

  always_ff @(posedge clk) begin
    if (!resetn) begin
      dirty <= '0;
      lru   <= '0;
    end else if (hit_update) begin
      lru[lookup_index] <= ~hit_way;  // the other way becomes LRU
      if (hit_store) begin
        dirty[hit_way][lookup_index] <= 1'b1;
      end
    end else if (fill_update) begin
      // freshly refilled line is clean and most recently used
      dirty[victim_way][lookup_index] <= 1'b0;
      lru[lookup_index]               <= ~victim_way;
    end else if (clean_victim) begin
      dirty[victim_way][lookup_index] <= 1'b0;
    end
  end

endmodule

/* src/dcache_store_merge.sv */
/*
  store buffer for store hits.
  overlays the strobed bytes of the store word onto the line read
  from the hit way, and registers the result on capture (end of the
  LOOKUP cycle). the controller writes merged_line into the data
  array during the following STORE cycle.
*/
module dcache_store_merge import dcache_pkg::*; (
  input  logic              clk,
  input  logic              capture,
  input  line_t             hit_line,
  input  logic [1:0]        word_sel,
  input  logic [3:0]        wstrb,
  input  logic [WORD_W-1:0] wdata,
  output line_t             merged_line
);

  line_t merged_d;

  always_comb begin
    merged_d = hit_line;
    for (int b = 0; b < WORD_W/8; b++) begin
      if (wstrb[b]) begin
        merged_d[word_sel][8*b +: 8] = wdata[8*b +: 8];  // data already in lane
      end
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      merged_line <= merged_d;
    end
  end

endmodule

/* src/dcache_ctrl.sv */
/*
  cache controller: request buffer, state machine and both handshakes.
  a request is read from the arrays in the cycle it is accepted and
  checked in LOOKUP. load hits may accept the next request in LOOKUP.
  misses write back a dirty victim, refill the line and then replay
  the buffered request through LOOKUP. after reset the tag arrays are
  swept to clear every valid bit before the first request is taken.
*/
module dcache_ctrl import dcache_pkg::*; #(
  parameter int INDEX_W = 4
) (
  input  logic                                    clk,
  input  logic                                    resetn,
  input  logic                                    req_valid,
  input  logic                                    req_we,
  input  logic [ADDR_W-1:0]                       req_addr,
  input  logic [3:0]                              req_wstrb,
  input  logic [WORD_W-1:0]                       req_wdata,
  output logic                                    addr_ok,
  output logic                                    data_ok,
  output logic [WORD_W-1:0]                       rdata,
  output logic                                    rd_req,
  output logic [ADDR_W-1:0]                       rd_addr,
  input  logic                                    rd_rdy,
  input  logic                                    ret_valid,
  input  line_t                                   ret_data,
  output logic                                    wr_req,
  output logic [ADDR_W-1:0]                       wr_addr,
  output line_t                                   wr_data,
  input  logic                                    wr_rdy,
  input  logic                                    wr_valid,
  input  logic [1:0]                              way_hit,
  input  logic                                    victim_way,
  input  logic                                    victim_dirty,
  input  logic [1:0][ADDR_W-INDEX_W-OFFSET_W-1:0] way_tag,
  input  line_t [1:0]                             way_lines,
  input  line_t                                   merged_line,
  output logic                                    ram_en,
  output logic [1:0]                              tag_we,
  output logic [1:0]                              data_we,
  output logic [INDEX_W-1:0]                      ram_index,
  output logic [ADDR_W-INDEX_W-OFFSET_W-1:0]      tag_wtag,
  output logic                                    tag_wvalid,
  output line_t                                   data_wline,
  output line_t                                   hit_line,
  output logic [ADDR_W-INDEX_W-OFFSET_W-1:0]      req_tag_q,
  output logic [INDEX_W-1:0]                      req_index_q,
  output logic                                    hit_update,
  output logic                                    hit_store,
  output logic                                    fill_update,
  output logic                                    clean_victim,
  output logic                                    capture,
  output logic [1:0]                              word_sel,
  output logic [3:0]                              req_wstrb_q,
  output logic [WORD_W-1:0]                       req_wdata_q
);

  localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;

  ctrl_state_e        state, next_state;
  logic               req_we_q;
  logic               retry_q;     // buffered request must be looked up again
  logic               sweep_q;     // clearing valid bits after reset
  logic [INDEX_W-1:0] sweep_idx;
  logic               store_way_q;
  logic               hit, lookup_hit, accept, retry_look, fill_wr;

  assign hit        = |way_hit;
  assign lookup_hit = (state == LOOKUP) && hit;
  assign addr_ok    = !sweep_q && ((state == IDLE && !retry_q) ||
                                   (lookup_hit && !req_we_q));
  assign accept     = req_valid && addr_ok;
  assign retry_look = (state == IDLE) && retry_q;
  assign fill_wr    = (state == REFILL) && ret_valid;

  assign data_ok  = lookup_hit;
  assign hit_line = way_hit[1] ? way_lines[1] : way_lines[0];
  assign rdata    = hit_line[word_sel];

  assign hit_update   = lookup_hit;
  assign hit_store    = lookup_hit && req_we_q;
  assign capture      = hit_store;
  assign fill_update  = fill_wr;
  assign clean_victim = (state == WRITEBACK) && wr_valid;

  // array port: incoming request on accept, otherwise the buffered one
  assign ram_en     = sweep_q || accept || retry_look || (state == STORE) || fill_wr;
  assign ram_index  = sweep_q ? sweep_idx :
                      accept  ? req_addr[OFFSET_W +: INDEX_W] : req_index_q;
  assign tag_wtag   = req_tag_q;
  assign tag_wvalid = !sweep_q;
  assign data_wline = (state == STORE) ? merged_line : ret_data;

  always_comb begin
    for (int w = 0; w < 2; w++) begin
      tag_we[w]  = sweep_q || (fill_wr && victim_way == w);
      data_we[w] = ((state == STORE) && store_way_q == w) ||
                   (fill_wr && victim_way == w);
    end
  end

  // memory side, victim line held on the array outputs during the miss
  assign rd_req  = (state == MISS_CLEAN);
  assign rd_addr = {req_tag_q, req_index_q, {OFFSET_W{1'b0}}};
  assign wr_req  = (state == MISS_DIRTY);
  assign wr_addr = {way_tag[victim_way], req_index_q, {OFFSET_W{1'b0}}};
  assign wr_data = way_lines[victim_way];

  always_comb begin
    next_state = state;
    unique case (state)
      IDLE:       if (accept || retry_look) next_state = LOOKUP;
      LOOKUP: begin
        if (!hit)          next_state = victim_dirty ? MISS_DIRTY : MISS_CLEAN;
        else if (req_we_q) next_state = STORE;
        else if (!accept)  next_state = IDLE;
      end
      STORE:      next_state = IDLE;
      MISS_DIRTY: if (wr_rdy)    next_state = WRITEBACK;
      WRITEBACK:  if (wr_valid)  next_state = MISS_CLEAN;
      MISS_CLEAN: if (rd_rdy)    next_state = REFILL;
      REFILL:     if (ret_valid) next_state = IDLE;
      default:    next_state = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state     <= IDLE;
      retry_q   <= 1'b0;
      sweep_q   <= 1'b1;
      sweep_idx <= '0;
    end else begin
      state <= next_state;
      if (fill_wr) begin
        retry_q <= 1'b1;
      end else if (retry_look) begin
        retry_q <= 1'b0;
      end
      if (sweep_q) begin
        sweep_idx <= sweep_idx + 1'b1;
        if (&sweep_idx) sweep_q <= 1'b0;  // last set cleared
      end
    end
  end

  // request buffer
  always_ff @(posedge clk) begin
    if (accept) begin
      req_we_q    <= req_we;
      req_tag_q   <= req_addr[ADDR_W-1 -: TAG_W];
      req_index_q <= req_addr[OFFSET_W +: INDEX_W];
      word_sel    <= req_addr[3:2];
      req_wstrb_q <= req_wstrb;
      req_wdata_q <= req_wdata;
    end
    if (capture) begin
      store_way_q <= way_hit[1];
    end
  end

endmodule

/* src/dcache_top.sv */
/*
  two-way set-associative write-back data cache, top level.
  CPU side uses valid/addr_ok/data_ok; memory side moves whole lines
  with rd_req/rd_rdy/ret_valid and wr_req/wr_rdy/wr_valid.
  INDEX_W sets the number of sets and is passed to every block.
*/
module dcache_top import dcache_pkg::*; #(
  parameter int INDEX_W = 4
) (
  input  logic              clk,
  input  logic              resetn,
  input  logic              req_valid,
  input  logic              req_we,
  input  logic [ADDR_W-1:0] req_addr,
  input  logic [3:0]        req_wstrb,
  input  logic [WORD_W-1:0] req_wdata,
  output logic              addr_ok,
  output logic              data_ok,
  output logic [WORD_W-1:0] rdata,
  output logic              rd_req,
  output logic [ADDR_W-1:0] rd_addr,
  input  logic              rd_rdy,
  input  logic              ret_valid,
  input  line_t             ret_data,
  output logic              wr_req,
  output logic [ADDR_W-1:0] wr_addr,
  output line_t             wr_data,
  input  logic              wr_rdy,
  input  logic              wr_valid
);

  localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;

  typedef struct packed {
    logic             valid;
    logic [TAG_W-1:0] tag;
  } tag_entry_t;

  tag_entry_t             tag_din;
  tag_entry_t [1:0]       tag_dout;
  logic [1:0][TAG_W-1:0]  way_tag;
  logic [1:0]             way_valid, way_hit, tag_we, data_we;
  line_t [1:0]            way_lines;
  line_t                  merged_line, data_wline, hit_line;
  logic                   ram_en, tag_wvalid, victim_way, victim_dirty;
  logic [INDEX_W-1:0]     ram_index, req_index_q;
  logic [TAG_W-1:0]       tag_wtag, req_tag_q;
  logic                   hit_update, hit_store, fill_update, clean_victim, capture;
  logic [1:0]             word_sel;
  logic [3:0]             req_wstrb_q;
  logic [WORD_W-1:0]      req_wdata_q;

  assign tag_din = '{valid: tag_wvalid, tag: tag_wtag};

  for (genvar w = 0; w < 2; w++) begin : g_way
    assign way_tag[w]   = tag_dout[w].tag;
    assign way_valid[w] = tag_dout[w].valid;

    cache_ram #(.INDEX_W(INDEX_W), .payload_t(tag_entry_t)) u_tag_ram (
      .clk, .en(ram_en), .we(tag_we[w]), .index(ram_index),
      .din(tag_din), .dout(tag_dout[w])
    );
    cache_ram #(.INDEX_W(INDEX_W), .payload_t(line_t)) u_data_ram (
      .clk, .en(ram_en), .we(data_we[w]), .index(ram_index),
      .din(data_wline), .dout(way_lines[w])
    );
  end

  dcache_ctrl #(.INDEX_W(INDEX_W)) u_ctrl (.*);

  dcache_tag_check #(.INDEX_W(INDEX_W)) u_tag_check (
    .clk, .resetn, .lookup_tag(req_tag_q), .lookup_index(req_index_q),
    .way_tag, .way_valid, .hit_update, .hit_store, .fill_update, .clean_victim,
    .way_hit, .victim_way, .victim_dirty
  );

  dcache_store_merge u_store_merge (
    .clk, .capture, .hit_line, .word_sel, .wstrb(req_wstrb_q),
    .wdata(req_wdata_q), .merged_line
  );

endmodule

/* bench/dcache_asserts.sv */
/*
  handshake properties of the cache controller.
  bound into dcache_ctrl from the testbench top.
*/
module dcache_asserts import dcache_pkg::*; (
  input logic              clk,
  input logic              resetn,
  input logic              req_valid,
  input logic              addr_ok,
  input logic              data_ok,
  input logic              rd_req,
  input logic [ADDR_W-1:0] rd_addr,
  input logic              rd_rdy,
  input logic              wr_req,
  input logic [ADDR_W-1:0] wr_addr,
  input line_t             wr_data,
  input logic              wr_rdy
);

  int pending;  // accepted, no data_ok yet

  always_ff @(posedge clk) begin
    if (!resetn) begin
      pending <= 0;
    end else begin
      pending <= pending + int'(req_valid && addr_ok) - int'(data_ok);
    end
  end

  a_rd_hold: assert property (@(posedge clk) disable iff (!resetn)
    rd_req && !rd_rdy |=> rd_req && $stable(rd_addr))
    else $error("rd_req or rd_addr changed before rd_rdy");

  a_wr_hold: assert property (@(posedge clk) disable iff (!resetn)
    wr_req && !wr_rdy |=> wr_req && $stable(wr_addr) && $stable(wr_data))
    else $error("wr_req, wr_addr or wr_data changed before wr_rdy");

  a_one_req: assert property (@(posedge clk) disable iff (!resetn)
    !(rd_req && wr_req))
    else $error("rd_req and wr_req high together");

  a_data_ok: assert property (@(posedge clk) disable iff (!resetn)
    data_ok |-> pending > 0)
    else $error("data_ok without an accepted request");

endmodule

/* bench/tb_clock.sv */
/*
  clock and reset source for the cache testbench.
  resetn is held low for RESET_CYCLES rising edges, then released.
*/
module tb_clock #(
  parameter int PERIOD       = 8,
  parameter int RESET_CYCLES = 8
) (
  output logic clk,
  output logic resetn
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD/2) clk = ~clk;
  end

  initial begin
    resetn = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    resetn <= 1'b1;
  end

endmodule

/* bench/tb_checker.sv */
/*
  watches the cache ports and compares them against a byte-level
  reference memory. stores update the reference in acceptance order,
  each accepted request queues its expected load word, and writebacks
  and refill addresses are checked against it. counts go to the top.
*/
module tb_checker import dcache_pkg::*; #(
  parameter int DATA_OK_TIMEOUT = 200
) (
  input  logic              clk,
  input  logic              resetn,
  input  logic              req_valid,
  input  logic              req_we,
  input  logic [ADDR_W-1:0] req_addr,
  input  logic [3:0]        req_wstrb,
  input  logic [WORD_W-1:0] req_wdata,
  input  logic              addr_ok,
  input  logic              data_ok,
  input  logic [WORD_W-1:0] rdata,
  input  logic              rd_req,
  input  logic [ADDR_W-1:0] rd_addr,
  input  logic              rd_rdy,
  input  logic              wr_req,
  input  logic              wr_rdy,
  input  logic [ADDR_W-1:0] wr_addr,
  input  line_t             wr_data,
  output int                mismatches,
  output int                failures,
  output int                outstanding
);

  typedef struct packed {
    logic              is_load;
    logic              must_hit;  // same line as the request before
    logic [ADDR_W-1:0] addr;
    logic [WORD_W-1:0] expected;
    int                accepted_at;
  } pending_t;

  pending_t   pending [$];
  logic [7:0] ref_mem [1024];
  bit         dirty_line [int];  // lines stored to since their refill
  int         cycle;
  bit         started, ready_seen, have_last, timeout_seen;
  int         last_line;

  function automatic logic [WORD_W-1:0] ref_word(input logic [ADDR_W-1:0] addr);
    return {ref_mem[{addr[9:2], 2'd3}], ref_mem[{addr[9:2], 2'd2}],
            ref_mem[{addr[9:2], 2'd1}], ref_mem[{addr[9:2], 2'd0}]};
  endfunction

  initial begin
    logic [WORD_W-1:0] fill;
    for (int a = 0; a < 1024; a++) begin
      fill       = ~(WORD_W'(a) >> 2);  // word address inverted
      ref_mem[a] = fill[8*(a%4) +: 8];
    end
  end

  always @(posedge clk) begin : compare
    pending_t p;
    line_t    exp_line;
    if (resetn) begin
      cycle++;
      if (!started && (data_ok || rd_req || wr_req)) begin
        failures++;
        $display("cache active before the first request");
      end
      if (!started && ready_seen && !addr_ok) begin
        failures++;
        $display("addr_ok dropped before the first request");
      end
      if (addr_ok) ready_seen = 1'b1;
      if (rd_req && pending.size() > 0 && pending[0].must_hit) begin
        failures++;
        $display("rd_req for a request that should hit, addr %h", pending[0].addr);
      end

      // the missing request is always the oldest outstanding one
      if (rd_req && rd_rdy) begin
        if (pending.size() == 0) begin
          failures++;
          $display("line read with no request outstanding, addr %h", rd_addr);
        end else if (rd_addr !== {pending[0].addr[ADDR_W-1:4], 4'h0}) begin
          mismatches++;
          $display("mismatch refill_addr: expected %h, actual %h",
                   {pending[0].addr[ADDR_W-1:4], 4'h0}, rd_addr);
        end
      end

      if (data_ok && pending.size() == 0) begin
        failures++;
        $display("data_ok without an outstanding request");
      end else if (data_ok) begin
        p = pending.pop_front();
        if (p.is_load && rdata !== p.expected) begin
          mismatches++;
          $display("mismatch load_data addr %h: expected %h, actual %h",
                   p.addr, p.expected, rdata);
        end
        if (p.must_hit && cycle - p.accepted_at != 1) begin
          mismatches++;
          $display("mismatch hit_latency addr %h: expected 1, actual %0d",
                   p.addr, cycle - p.accepted_at);
        end
      end

      if (wr_req && wr_rdy) begin
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
          exp_line[w] = ref_word({wr_addr[ADDR_W-1:4], 2'(w), 2'b00});
        end
        if (!dirty_line.exists(int'(wr_addr >> 4))) begin
          failures++;
          $display("writeback of line %h, which got no store since its refill", wr_addr);
        end
        dirty_line.delete(int'(wr_addr >> 4));
        if (wr_data !== exp_line) begin
          mismatches++;
          $display("mismatch writeback addr %h: expected %h, actual %h",
                   wr_addr, exp_line, wr_data);
        end
      end

      if (req_valid && addr_ok) begin
        started       = 1'b1;
        p.is_load     = !req_we;
        p.must_hit    = have_last && int'(req_addr >> 4) == last_line;
        p.addr        = req_addr;
        p.expected    = ref_word(req_addr);
        p.accepted_at = cycle;
        if (req_we) begin
          for (int b = 0; b < 4; b++) begin
            if (req_wstrb[b]) ref_mem[{req_addr[9:2], 2'(b)}] = req_wdata[8*b +: 8];
          end
          dirty_line[int'(req_addr >> 4)] = 1'b1;
        end
        pending.push_back(p);
        last_line = int'(req_addr >> 4);
        have_last = 1'b1;
      end

      if (pending.size() > 0 && !timeout_seen &&
          cycle - pending[0].accepted_at > DATA_OK_TIMEOUT) begin
        failures++;
        timeout_seen = 1'b1;
        $display("timeout: no data_ok within %0d cycles for addr %h",
                 DATA_OK_TIMEOUT, pending[0].addr);
      end
      outstanding <= pending.size();
    end
  end

endmodule

/* bench/tb_top.sv */
/*
  testbench top for the data cache.
  drives seeded random loads and stores over 4 tags x 4 sets x 4 words,
  and answers the line requests from a backing memory with random
  delays. tb_checker does the comparing; this module ends the run.
*/
module tb_top import dcache_pkg::*; ();

  localparam int NUM_REQ    = 500;
  localparam int WAIT_LIMIT = 300;

  logic              clk, resetn;
  logic              req_valid, req_we, addr_ok, data_ok;
  logic [ADDR_W-1:0] req_addr, rd_addr, wr_addr;
  logic [3:0]        req_wstrb;
  logic [WORD_W-1:0] req_wdata, rdata;
  logic              rd_req, rd_rdy, ret_valid, wr_req, wr_rdy, wr_valid;
  line_t             ret_data, wr_data;
  logic [WORD_W-1:0] backing [256];
  int                mismatches, failures, outstanding;
  bit                timed_out;

  tb_clock #(.PERIOD(8), .RESET_CYCLES(8)) u_clock (.clk, .resetn);

  dcache_top #(.INDEX_W(4)) u_dut (.*);

  tb_checker u_checker (.*);

  bind dcache_ctrl dcache_asserts u_asserts (
    .clk, .resetn, .req_valid, .addr_ok, .data_ok, .rd_req, .rd_addr, .rd_rdy,
    .wr_req, .wr_addr, .wr_data, .wr_rdy
  );

  // tag in bits 9:8, set in 5:4, word in 3:2
  function automatic logic [ADDR_W-1:0] random_addr();
    return {22'd0, 2'($urandom), 2'b00, 2'($urandom), 2'($urandom), 2'b00};
  endfunction

  task automatic drive_request();
    req_valid <= 1'b1;
    req_we    <= 1'($urandom);
    req_addr  <= random_addr();
    req_wstrb <= 4'($urandom);
    req_wdata <= $urandom;
  endtask

  task automatic finish_run();
    $display("error counts: %0d mismatches, %0d other", mismatches,
             failures + int'(timed_out));
    if (timed_out || mismatches != 0 || failures != 0) begin
      $display("Test failed");
    end else begin
      $display("Test completed successfully");
    end
    $finish;
  endtask

  initial begin
    for (int i = 0; i < 256; i++) backing[i] = ~WORD_W'(i);  // word address inverted
  end

  // line-wide memory, one transfer at a time
  always begin : memory_model
    logic [ADDR_W-1:0] line_addr;
    line_t             line;
    @(posedge clk);
    if (resetn && rd_req) begin
      line_addr = rd_addr;
      repeat ($urandom % 6) @(posedge clk);
      rd_rdy <= 1'b1;
      @(posedge clk);
      rd_rdy <= 1'b0;
      repeat ($urandom % 6) @(posedge clk);
      for (int w = 0; w < WORDS_PER_LINE; w++) line[w] = backing[{line_addr[9:4], 2'(w)}];
      ret_data  <= line;
      ret_valid <= 1'b1;
      @(posedge clk);
      ret_valid <= 1'b0;
    end else if (resetn && wr_req) begin
      repeat ($urandom % 6) @(posedge clk);
      wr_rdy <= 1'b1;
      @(posedge clk);
      wr_rdy <= 1'b0;
      for (int w = 0; w < WORDS_PER_LINE; w++) backing[{wr_addr[9:4], 2'(w)}] = wr_data[w];
      repeat ($urandom % 6) @(posedge clk);
      wr_valid <= 1'b1;
      @(posedge clk);
      wr_valid <= 1'b0;
    end
  end

  initial begin : stimulus
    int waited;
    void'($urandom(5));
    req_valid = 1'b0;
    req_we    = 1'b0;
    req_addr  = '0;
    req_wstrb = '0;
    req_wdata = '0;
    rd_rdy    = 1'b0;
    ret_valid = 1'b0;
    ret_data  = '0;
    wr_rdy    = 1'b0;
    wr_valid  = 1'b0;

    // reset, then the valid-bit sweep
    waited = 0;
    @(posedge clk);
    while (!(resetn && addr_ok) && waited < WAIT_LIMIT) begin
      waited++;
      @(posedge clk);
    end
    if (waited >= WAIT_LIMIT) begin
      $display("timeout: addr_ok never came up after reset");
      timed_out = 1'b1;
    end else begin
      repeat (3) @(posedge clk);  // idle, checker watches for stray activity
      for (int i = 0; i < NUM_REQ && !timed_out; i++) begin
        drive_request();
        waited = 0;
        @(posedge clk);
        while (!addr_ok && waited < WAIT_LIMIT) begin
          waited++;
          @(posedge clk);
        end
        if (waited >= WAIT_LIMIT) begin
          $display("timeout: request %0d was not accepted", i);
          timed_out = 1'b1;
        end else if ($urandom % 4 == 0) begin
          req_valid <= 1'b0;
          repeat ($urandom % 3 + 1) @(posedge clk);
        end
      end
      req_valid <= 1'b0;
      waited = 0;
      repeat (2) @(posedge clk);
      while (outstanding != 0 && waited < WAIT_LIMIT) begin
        waited++;
        @(posedge clk);
      end
      if (!timed_out && waited >= WAIT_LIMIT) begin
        $display("timeout: %0d requests still without data_ok", outstanding);
        timed_out = 1'b1;
      end
    end
    finish_run();
  end

endmodule

/* files.f */
src/dcache_pkg.sv
src/cache_ram.sv
src/dcache_tag_check.sv
src/dcache_store_merge.sv
src/dcache_ctrl.sv
src/dcache_top.sv
bench/dcache_asserts.sv
bench/tb_clock.sv
bench/tb_checker.sv
bench/tb_top.sv

/* run.sh */
#!/usr/bin/env bash
# builds the cache testbench with Verilator and runs it
# the run fails when the log holds the fail message or the simulator aborts
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f files.f \
  -Mdir obj_dir -o sim_tb &&
  ./obj_dir/sim_tb 2>&1 | tee sim.log ||
  { echo "build or simulation aborted"; exit 1; }
grep -q "Test failed" sim.log && exit 1 || exit 0
